/* hw/rvfi_cfg_pkg.sv */
// ----------------------------------------
// Trace monitor configuration
// Sizes and widths of the monitored core
// ----------------------------------------

package rvfi_cfg_pkg;

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  localparam int unsigned XLEN = 32;  // Integer register width
  localparam int unsigned VLEN = 32;  // Virtual address width
  localparam int unsigned INSN_BITS = 32;  // Full-size instruction word

  // Byte lanes of one data word
  localparam int unsigned BE_BITS = XLEN / 8;

  // ----------------------------------------
  // Scoreboard and register file
  // ----------------------------------------
  localparam int unsigned SB_ENTRIES = 8;  // In-flight transactions
  localparam int unsigned TRANS_ID_BITS = $clog2(SB_ENTRIES);
  localparam int unsigned REG_ADDR_BITS = 5;  // x0..x31

  // Sticky interrupt/trap code
  localparam int unsigned INTR_BITS = 3;

endpackage

/* hw/rvfi_trace_pkg.sv */
// ----------------------------------------
// Trace record format
// Field types, FU and cause encodings
// ----------------------------------------

package rvfi_trace_pkg;

  // ----------------------------------------
  // Field types
  // ----------------------------------------
  typedef logic [rvfi_cfg_pkg::XLEN-1:0] xlen_t;
  typedef logic [rvfi_cfg_pkg::VLEN-1:0] vaddr_t;
  typedef logic [rvfi_cfg_pkg::TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [rvfi_cfg_pkg::REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [rvfi_cfg_pkg::BE_BITS-1:0] be_t;
  typedef logic [rvfi_cfg_pkg::INSN_BITS-1:0] insn_t;

  // Unit type at the load/store control point
  typedef enum logic [1:0] {
    FU_NONE,
    FU_LOAD,
    FU_STORE,
    FU_OTHER
  } lsu_fu_e;

  // Environment calls retire, other exceptions do not
  typedef enum logic [rvfi_cfg_pkg::XLEN-1:0] {
    CAUSE_ECALL_U = 32'd8,
    CAUSE_ECALL_S = 32'd9,
    CAUSE_ECALL_M = 32'd11
  } env_call_cause_e;

  // Sticky intr codes
  localparam logic [rvfi_cfg_pkg::INTR_BITS-1:0] INTR_ASYNC = 3'd5;  // Interrupt taken
  localparam logic [rvfi_cfg_pkg::INTR_BITS-1:0] INTR_SYNC = 3'd3;  // Synchronous trap

  // ----------------------------------------
  // Side-table entry
  // ----------------------------------------
  typedef struct packed {
    xlen_t  rs1_rdata;
    xlen_t  rs2_rdata;
    vaddr_t lsu_addr;
    be_t    lsu_rmask;
    be_t    lsu_wmask;
    xlen_t  lsu_wdata;
    insn_t  insn;  // Already truncated when compressed
  } sb_entry_t;

endpackage

/* hw/rvfi_issue_wr_if.sv */
// ----------------------------------------
// Issue-time write into the side table
// ----------------------------------------

`timescale 1ns/1ps

interface rvfi_issue_wr_if;
  import rvfi_trace_pkg::*;

  logic      wr_valid;  // Write strobe, one per issued instruction
  trans_id_t wr_id;
  insn_t     wr_insn;
  xlen_t     wr_rs1;
  xlen_t     wr_rs2;

  modport writer(
    output wr_valid, wr_id, wr_insn, wr_rs1, wr_rs2
  );

  modport store(
    input wr_valid, wr_id, wr_insn, wr_rs1, wr_rs2
  );

endinterface

/* hw/rvfi_issue_capture.sv */
// ----------------------------------------
// Issue capture
// Holds the decoded instruction, emits issue writes
// ----------------------------------------

`timescale 1ns/1ps

module rvfi_issue_capture (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic                      fetch_valid_i,
  input  rvfi_trace_pkg::insn_t     fetch_insn_i,
  input  logic                      fetch_compressed_i,
  input  logic                      issue_ack_i,
  input  logic                      decoded_valid_i,
  input  logic                      decoded_ack_i,
  input  logic                      flush_unissued_i,
  input  rvfi_trace_pkg::trans_id_t issue_pointer_i,
  input  rvfi_trace_pkg::xlen_t     rs1_rdata_i,
  input  rvfi_trace_pkg::xlen_t     rs2_rdata_i,
  rvfi_issue_wr_if.writer           wr_o
);
  import rvfi_trace_pkg::*;

  insn_t fetch_trunc;
  logic  buf_valid_d, buf_valid_q;
  insn_t buf_insn_d, buf_insn_q;

  // Compressed words keep only their low half
  assign fetch_trunc = fetch_compressed_i ? {16'b0, fetch_insn_i[15:0]} : fetch_insn_i;

  // ----------------------------------------
  // One-entry decode buffer
  // ----------------------------------------
  always_comb begin
    buf_valid_d = buf_valid_q;
    buf_insn_d  = buf_insn_q;

    if (issue_ack_i) begin
      buf_valid_d = 1'b0;  // Entry left decode
    end

    // Free slot takes whatever fetch offers this cycle
    if (!buf_valid_d) begin
      buf_valid_d = fetch_valid_i;
      buf_insn_d  = fetch_trunc;
    end

    if (flush_i) begin
      buf_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else begin
      buf_valid_q <= buf_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    buf_insn_q <= buf_insn_d;
  end

  // ----------------------------------------
  // Issue write
  // ----------------------------------------
  assign wr_o.wr_valid = decoded_valid_i && decoded_ack_i && !flush_unissued_i;
  assign wr_o.wr_id    = issue_pointer_i;
  assign wr_o.wr_insn  = buf_insn_q;  // Word held since decode
  assign wr_o.wr_rs1   = rs1_rdata_i;
  assign wr_o.wr_rs2   = rs2_rdata_i;

endmodule

/* hw/rvfi_side_table.sv */
// ----------------------------------------
// Side table
// Per-transaction operands and memory annotations
// ----------------------------------------

`timescale 1ns/1ps

module rvfi_side_table (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  rvfi_issue_wr_if.store            wr_i,
  input  rvfi_trace_pkg::lsu_fu_e   lsu_fu_i,
  input  rvfi_trace_pkg::be_t       lsu_be_i,
  input  rvfi_trace_pkg::vaddr_t    lsu_vaddr_i,
  input  rvfi_trace_pkg::trans_id_t lsu_id_i,
  input  rvfi_trace_pkg::xlen_t     store_data_i,
  input  rvfi_trace_pkg::trans_id_t rd_id_i,
  output rvfi_trace_pkg::sb_entry_t rd_entry_o
);
  import rvfi_cfg_pkg::*;
  import rvfi_trace_pkg::*;

  sb_entry_t mem_d [SB_ENTRIES];
  sb_entry_t mem_q [SB_ENTRIES];
  be_t       lsu_rmask;
  be_t       lsu_wmask;

  // Byte enables split by direction
  assign lsu_rmask = (lsu_fu_i == FU_LOAD) ? lsu_be_i : '0;
  assign lsu_wmask = (lsu_fu_i == FU_STORE) ? lsu_be_i : '0;

  // ----------------------------------------
  // Next-state, both writers by field
  // ----------------------------------------
  always_comb begin
    mem_d = mem_q;

    // Issue write starts a fresh entry
    if (wr_i.wr_valid) begin
      mem_d[wr_i.wr_id].rs1_rdata = wr_i.wr_rs1;
      mem_d[wr_i.wr_id].rs2_rdata = wr_i.wr_rs2;
      mem_d[wr_i.wr_id].insn      = wr_i.wr_insn;
      mem_d[wr_i.wr_id].lsu_addr  = '0;
      mem_d[wr_i.wr_id].lsu_rmask = '0;
      mem_d[wr_i.wr_id].lsu_wmask = '0;
      mem_d[wr_i.wr_id].lsu_wdata = '0;
    end

    // Annotation applied last so it wins on the same entry
    if (lsu_rmask != '0) begin
      mem_d[lsu_id_i].lsu_addr  = lsu_vaddr_i;
      mem_d[lsu_id_i].lsu_rmask = lsu_rmask;
    end else if (lsu_wmask != '0) begin
      mem_d[lsu_id_i].lsu_addr  = lsu_vaddr_i;
      mem_d[lsu_id_i].lsu_wmask = lsu_wmask;
      mem_d[lsu_id_i].lsu_wdata = store_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < SB_ENTRIES; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      mem_q <= mem_d;
    end
  end

  assign rd_entry_o = mem_q[rd_id_i];  // Combinational read at commit

endmodule

/* hw/rvfi_commit_pack.sv */
// ----------------------------------------
// Commit packer
// Classifies retirements, registers the record
// ----------------------------------------

`timescale 1ns/1ps

module rvfi_commit_pack (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  rvfi_trace_pkg::trans_id_t              commit_pointer_i,
  output rvfi_trace_pkg::trans_id_t              rd_id_o,
  input  rvfi_trace_pkg::sb_entry_t              rd_entry_i,
  input  logic                                   commit_valid_i,
  input  logic                                   commit_ack_i,
  input  logic                                   commit_drop_i,
  input  logic                                   ex_valid_i,
  input  rvfi_trace_pkg::xlen_t                  ex_cause_i,
  input  logic [1:0]                             priv_lvl_i,
  input  rvfi_trace_pkg::reg_addr_t              rs1_addr_i,
  input  rvfi_trace_pkg::reg_addr_t              rs2_addr_i,
  input  rvfi_trace_pkg::reg_addr_t              rd_addr_i,
  input  rvfi_trace_pkg::xlen_t                  wdata_i,
  input  rvfi_trace_pkg::xlen_t                  result_i,
  input  rvfi_trace_pkg::vaddr_t                 pc_i,
  output logic                                   rvfi_valid_o,
  output rvfi_trace_pkg::insn_t                  rvfi_insn_o,
  output logic                                   rvfi_trap_o,
  output logic [rvfi_cfg_pkg::INTR_BITS-1:0]     rvfi_intr_o,
  output rvfi_trace_pkg::xlen_t                  rvfi_cause_o,
  output logic [1:0]                             rvfi_mode_o,
  output rvfi_trace_pkg::reg_addr_t              rvfi_rs1_addr_o,
  output rvfi_trace_pkg::reg_addr_t              rvfi_rs2_addr_o,
  output rvfi_trace_pkg::reg_addr_t              rvfi_rd_addr_o,
  output rvfi_trace_pkg::xlen_t                  rvfi_rd_wdata_o,
  output rvfi_trace_pkg::vaddr_t                 rvfi_pc_rdata_o,
  output rvfi_trace_pkg::vaddr_t                 rvfi_mem_addr_o,
  output rvfi_trace_pkg::be_t                    rvfi_mem_rmask_o,
  output rvfi_trace_pkg::be_t                    rvfi_mem_wmask_o,
  output rvfi_trace_pkg::xlen_t                  rvfi_mem_wdata_o,
  output rvfi_trace_pkg::xlen_t                  rvfi_mem_rdata_o,
  output rvfi_trace_pkg::xlen_t                  rvfi_rs1_rdata_o,
  output rvfi_trace_pkg::xlen_t                  rvfi_rs2_rdata_o
);
  import rvfi_cfg_pkg::*;
  import rvfi_trace_pkg::*;

  logic                 exception;
  logic                 is_ecall;
  logic                 retire_valid;
  logic [INTR_BITS-1:0] intr_d, intr_q;

  assign rd_id_o = commit_pointer_i;

  // ----------------------------------------
  // Classification
  // ----------------------------------------
  assign exception = commit_valid_i && ex_valid_i && !commit_drop_i;
  assign is_ecall  = (ex_cause_i == CAUSE_ECALL_U) || (ex_cause_i == CAUSE_ECALL_S) ||
                     (ex_cause_i == CAUSE_ECALL_M);

  // Ecalls still count as executed
  assign retire_valid = (commit_ack_i && !ex_valid_i && !commit_drop_i) ||
                        (exception && is_ecall);

  always_comb begin
    intr_d = intr_q;
    if (exception) begin
      intr_d = ex_cause_i[XLEN-1] ? INTR_ASYNC : INTR_SYNC;
    end
    if (retire_valid) begin
      intr_d = '0;  // Reported once, then cleared
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_q       <= '0;
      rvfi_valid_o <= 1'b0;
      rvfi_trap_o  <= 1'b0;
      rvfi_intr_o  <= '0;
    end else begin
      intr_q       <= intr_d;
      rvfi_valid_o <= retire_valid;
      rvfi_trap_o  <= exception && !ex_cause_i[XLEN-1];  // Sync trap, insn not executed
      rvfi_intr_o  <= intr_q;  // Code from earlier records
    end
  end

  // ----------------------------------------
  // Record payload
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    rvfi_insn_o      <= rd_entry_i.insn;
    rvfi_cause_o     <= ex_cause_i;
    rvfi_mode_o      <= priv_lvl_i;
    rvfi_rs1_addr_o  <= rs1_addr_i;
    rvfi_rs2_addr_o  <= rs2_addr_i;
    rvfi_rd_addr_o   <= rd_addr_i;
    rvfi_rd_wdata_o  <= wdata_i;
    rvfi_pc_rdata_o  <= pc_i;
    rvfi_mem_addr_o  <= rd_entry_i.lsu_addr;
    rvfi_mem_rmask_o <= rd_entry_i.lsu_rmask;
    rvfi_mem_wmask_o <= rd_entry_i.lsu_wmask;
    rvfi_mem_wdata_o <= rd_entry_i.lsu_wdata;
    rvfi_mem_rdata_o <= result_i;  // Load result from writeback
    rvfi_rs1_rdata_o <= rd_entry_i.rs1_rdata;
    rvfi_rs2_rdata_o <= rd_entry_i.rs2_rdata;
  end

endmodule

/* hw/rvfi_tracer.sv */
// ----------------------------------------
// RVFI retirement tracer, top level
// ----------------------------------------

`timescale 1ns/1ps

module rvfi_tracer (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Fetch and decode probes
  input  logic                               flush_i,
  input  logic                               fetch_valid_i,
  input  rvfi_trace_pkg::insn_t              fetch_insn_i,
  input  logic                               fetch_compressed_i,
  input  logic                               issue_ack_i,
  input  logic                               decoded_valid_i,
  input  logic                               decoded_ack_i,
  input  logic                               flush_unissued_i,
  input  rvfi_trace_pkg::trans_id_t          issue_pointer_i,
  input  rvfi_trace_pkg::xlen_t              rs1_rdata_i,
  input  rvfi_trace_pkg::xlen_t              rs2_rdata_i,
  // Load/store control probes
  input  rvfi_trace_pkg::lsu_fu_e            lsu_fu_i,
  input  rvfi_trace_pkg::be_t                lsu_be_i,
  input  rvfi_trace_pkg::vaddr_t             lsu_vaddr_i,
  input  rvfi_trace_pkg::trans_id_t          lsu_id_i,
  input  rvfi_trace_pkg::xlen_t              store_data_i,
  // Commit probes
  input  rvfi_trace_pkg::trans_id_t          commit_pointer_i,
  input  logic                               commit_valid_i,
  input  logic                               commit_ack_i,
  input  logic                               commit_drop_i,
  input  logic                               ex_valid_i,
  input  rvfi_trace_pkg::xlen_t              ex_cause_i,
  input  logic [1:0]                         priv_lvl_i,
  input  rvfi_trace_pkg::reg_addr_t          rs1_addr_i,
  input  rvfi_trace_pkg::reg_addr_t          rs2_addr_i,
  input  rvfi_trace_pkg::reg_addr_t          rd_addr_i,
  input  rvfi_trace_pkg::xlen_t              wdata_i,
  input  rvfi_trace_pkg::xlen_t              result_i,
  input  rvfi_trace_pkg::vaddr_t             pc_i,
  // Trace record
  output logic                               rvfi_valid_o,
  output rvfi_trace_pkg::insn_t              rvfi_insn_o,
  output logic                               rvfi_trap_o,
  output logic [rvfi_cfg_pkg::INTR_BITS-1:0] rvfi_intr_o,
  output rvfi_trace_pkg::xlen_t              rvfi_cause_o,
  output logic [1:0]                         rvfi_mode_o,
  output rvfi_trace_pkg::reg_addr_t          rvfi_rs1_addr_o,
  output rvfi_trace_pkg::reg_addr_t          rvfi_rs2_addr_o,
  output rvfi_trace_pkg::reg_addr_t          rvfi_rd_addr_o,
  output rvfi_trace_pkg::xlen_t              rvfi_rd_wdata_o,
  output rvfi_trace_pkg::vaddr_t             rvfi_pc_rdata_o,
  output rvfi_trace_pkg::vaddr_t             rvfi_mem_addr_o,
  output rvfi_trace_pkg::be_t                rvfi_mem_rmask_o,
  output rvfi_trace_pkg::be_t                rvfi_mem_wmask_o,
  output rvfi_trace_pkg::xlen_t              rvfi_mem_wdata_o,
  output rvfi_trace_pkg::xlen_t              rvfi_mem_rdata_o,
  output rvfi_trace_pkg::xlen_t              rvfi_rs1_rdata_o,
  output rvfi_trace_pkg::xlen_t              rvfi_rs2_rdata_o
);
  import rvfi_trace_pkg::*;

  trans_id_t rd_id;     // Commit pointer into the table
  sb_entry_t rd_entry;

  rvfi_issue_wr_if issue_wr ();

  rvfi_issue_capture i_issue_capture (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_insn_i       (fetch_insn_i),
    .fetch_compressed_i (fetch_compressed_i),
    .issue_ack_i        (issue_ack_i),
    .decoded_valid_i    (decoded_valid_i),
    .decoded_ack_i      (decoded_ack_i),
    .flush_unissued_i   (flush_unissued_i),
    .issue_pointer_i    (issue_pointer_i),
    .rs1_rdata_i        (rs1_rdata_i),
    .rs2_rdata_i        (rs2_rdata_i),
    .wr_o               (issue_wr.writer)
  );

  rvfi_side_table i_side_table (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_i         (issue_wr.store),
    .lsu_fu_i     (lsu_fu_i),
    .lsu_be_i     (lsu_be_i),
    .lsu_vaddr_i  (lsu_vaddr_i),
    .lsu_id_i     (lsu_id_i),
    .store_data_i (store_data_i),
    .rd_id_i      (rd_id),
    .rd_entry_o   (rd_entry)
  );

  rvfi_commit_pack i_commit_pack (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .commit_pointer_i (commit_pointer_i),
    .rd_id_o          (rd_id),
    .rd_entry_i       (rd_entry),
    .commit_valid_i   (commit_valid_i),
    .commit_ack_i     (commit_ack_i),
    .commit_drop_i    (commit_drop_i),
    .ex_valid_i       (ex_valid_i),
    .ex_cause_i       (ex_cause_i),
    .priv_lvl_i       (priv_lvl_i),
    .rs1_addr_i       (rs1_addr_i),
    .rs2_addr_i       (rs2_addr_i),
    .rd_addr_i        (rd_addr_i),
    .wdata_i          (wdata_i),
    .result_i         (result_i),
    .pc_i             (pc_i),
    .rvfi_valid_o     (rvfi_valid_o),
    .rvfi_insn_o      (rvfi_insn_o),
    .rvfi_trap_o      (rvfi_trap_o),
    .rvfi_intr_o      (rvfi_intr_o),
    .rvfi_cause_o     (rvfi_cause_o),
    .rvfi_mode_o      (rvfi_mode_o),
    .rvfi_rs1_addr_o  (rvfi_rs1_addr_o),
    .rvfi_rs2_addr_o  (rvfi_rs2_addr_o),
    .rvfi_rd_addr_o   (rvfi_rd_addr_o),
    .rvfi_rd_wdata_o  (rvfi_rd_wdata_o),
    .rvfi_pc_rdata_o  (rvfi_pc_rdata_o),
    .rvfi_mem_addr_o  (rvfi_mem_addr_o),
    .rvfi_mem_rmask_o (rvfi_mem_rmask_o),
    .rvfi_mem_wmask_o (rvfi_mem_wmask_o),
    .rvfi_mem_wdata_o (rvfi_mem_wdata_o),
    .rvfi_mem_rdata_o (rvfi_mem_rdata_o),
    .rvfi_rs1_rdata_o (rvfi_rs1_rdata_o),
    .rvfi_rs2_rdata_o (rvfi_rs2_rdata_o)
  );

endmodule

/* testbench/rvfi_tracer_assert.sv */
// ----------------------------------------
// Trace monitor output checks
// Quiet start and commit classification
// ----------------------------------------

`timescale 1ns/1ps

module rvfi_tracer_assert (
  input logic                               clk_i,
  input logic                               rst_ni,
  input logic                               commit_valid_i,
  input logic                               commit_ack_i,
  input logic                               commit_drop_i,
  input logic                               ex_valid_i,
  input rvfi_trace_pkg::xlen_t              ex_cause_i,
  input logic                               valid_i,
  input logic                               trap_i,
  input logic [rvfi_cfg_pkg::INTR_BITS-1:0] intr_i
);
  logic seen_commit_q;
  logic exc;
  logic ecall;
  logic any_failed;
  bit   idle_fail = 1'b0;
  bit   sync_fail = 1'b0;
  bit   ecall_fail = 1'b0;
  bit   async_fail = 1'b0;
  bit   drop_fail = 1'b0;

  assign exc   = commit_valid_i && ex_valid_i && !commit_drop_i;
  assign ecall = (ex_cause_i == 32'd8) || (ex_cause_i == 32'd9) || (ex_cause_i == 32'd11);
  assign any_failed = idle_fail | sync_fail | ecall_fail | async_fail | drop_fail;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_commit_q <= 1'b0;
    end else if (commit_valid_i || commit_ack_i) begin
      seen_commit_q <= 1'b1;  // First record lands with this edge
    end
  end

  // ----------------------------------------
  // Nothing reported before the first commit
  // ----------------------------------------
  quiet_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_commit_q |-> (!valid_i && !trap_i && intr_i == '0))
    else begin
      idle_fail = 1'b1;
      $error("Trace strobes went active before any commit");
    end

  // Classification one cycle after the commit probes
  sync_trap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(exc && !ex_cause_i[31] && !ecall) |-> (!valid_i && trap_i))
    else begin
      sync_fail = 1'b1;
      $error("Synchronous exception was not reported as a trap only");
    end

  ecall_retire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(exc && ecall) |-> (valid_i && trap_i))
    else begin
      ecall_fail = 1'b1;
      $error("Environment call was not reported as valid with trap");
    end

  async_intr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(exc && ex_cause_i[31]) |-> (!valid_i && !trap_i))
    else begin
      async_fail = 1'b1;
      $error("Interrupt was reported as valid or as a trap");
    end

  dropped_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(commit_ack_i && commit_drop_i) |-> !valid_i)
    else begin
      drop_fail = 1'b1;
      $error("Dropped commit produced a valid record");
    end

endmodule

bind rvfi_tracer rvfi_tracer_assert i_assert (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .commit_valid_i (commit_valid_i),
  .commit_ack_i   (commit_ack_i),
  .commit_drop_i  (commit_drop_i),
  .ex_valid_i     (ex_valid_i),
  .ex_cause_i     (ex_cause_i),
  .valid_i        (rvfi_valid_o),
  .trap_i         (rvfi_trap_o),
  .intr_i         (rvfi_intr_o)
);

/* testbench/tb_rvfi_tracer.sv */
// ----------------------------------------
// Trace monitor testbench
// Directed traffic against a reference scoreboard
// ----------------------------------------

`timescale 1ns/1ps

module tb_rvfi_tracer;
  import rvfi_cfg_pkg::*;
  import rvfi_trace_pkg::*;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       flush_i, fetch_valid_i, fetch_compressed_i, issue_ack_i;
  logic       decoded_valid_i, decoded_ack_i, flush_unissued_i;
  logic       commit_valid_i, commit_ack_i, commit_drop_i, ex_valid_i;
  insn_t      fetch_insn_i;
  trans_id_t  issue_pointer_i, lsu_id_i, commit_pointer_i;
  xlen_t      rs1_rdata_i, rs2_rdata_i, store_data_i, ex_cause_i, wdata_i, result_i;
  lsu_fu_e    lsu_fu_i;
  be_t        lsu_be_i;
  vaddr_t     lsu_vaddr_i, pc_i;
  logic [1:0] priv_lvl_i;
  reg_addr_t  rs1_addr_i, rs2_addr_i, rd_addr_i;

  // DUT record outputs
  logic                 rvfi_valid_o, rvfi_trap_o;
  logic [INTR_BITS-1:0] rvfi_intr_o;
  logic [1:0]           rvfi_mode_o;
  insn_t                rvfi_insn_o;
  reg_addr_t            rvfi_rs1_addr_o, rvfi_rs2_addr_o, rvfi_rd_addr_o;
  vaddr_t               rvfi_pc_rdata_o, rvfi_mem_addr_o;
  be_t                  rvfi_mem_rmask_o, rvfi_mem_wmask_o;
  xlen_t                rvfi_cause_o, rvfi_rd_wdata_o, rvfi_mem_wdata_o, rvfi_mem_rdata_o;
  xlen_t                rvfi_rs1_rdata_o, rvfi_rs2_rdata_o;

  // Reference state
  sb_entry_t   model [SB_ENTRIES];
  logic        held_valid;
  insn_t       held_insn;
  logic [2:0]  sticky_intr;
  logic [31:0] rng_state;

  always #50 clk_i = ~clk_i;

  rvfi_tracer i_dut (.*);

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    assert (act_v == exp_v)
    else abort_run($sformatf("FAIL time %0t %s expected 0x%08h actual 0x%08h",
                             $time, name, exp_v, act_v));
  endtask

  // Bound checks raise a flag, turn it into a stop here
  always @(negedge clk_i) begin
    if (i_dut.i_assert.any_failed) begin
      abort_run("A bound assertion on the trace outputs failed");
    end
  end

  task automatic clear_strobes();
    flush_i            = 1'b0;
    fetch_valid_i      = 1'b0;
    fetch_compressed_i = 1'b0;
    issue_ack_i        = 1'b0;
    decoded_valid_i    = 1'b0;
    decoded_ack_i      = 1'b0;
    flush_unissued_i   = 1'b0;
    lsu_fu_i           = FU_NONE;
    commit_valid_i     = 1'b0;
    commit_ack_i       = 1'b0;
    commit_drop_i      = 1'b0;
    ex_valid_i         = 1'b0;
  endtask

  task automatic fetch_word(input logic compressed);
    fetch_valid_i      = 1'b1;
    fetch_insn_i       = next_random();
    fetch_compressed_i = compressed;
  endtask

  task automatic issue_entry(input trans_id_t id);
    issue_ack_i     = 1'b1;
    decoded_valid_i = 1'b1;
    decoded_ack_i   = 1'b1;
    issue_pointer_i = id;
    rs1_rdata_i     = next_random();
    rs2_rdata_i     = next_random();
  endtask

  task automatic annotate_entry(input trans_id_t id, input lsu_fu_e fu);
    lsu_id_i     = id;
    lsu_fu_i     = fu;
    lsu_be_i     = 4'(next_random() % 32'd15 + 32'd1);  // Never zero
    lsu_vaddr_i  = next_random();
    store_data_i = next_random();
  endtask

  task automatic commit_entry(input trans_id_t id, input logic ex, input xlen_t cause,
                              input logic drop);
    commit_pointer_i = id;
    commit_valid_i   = 1'b1;
    commit_ack_i     = 1'b1;
    commit_drop_i    = drop;
    ex_valid_i       = ex;
    ex_cause_i       = cause;
    priv_lvl_i       = 2'(next_random());
    rs1_addr_i       = 5'(next_random());
    rs2_addr_i       = 5'(next_random());
    rd_addr_i        = 5'(next_random());
    wdata_i          = next_random();
    result_i         = next_random();
    pc_i             = next_random();
  endtask

  // ----------------------------------------
  // One clock with reference update and record check
  // ----------------------------------------
  task automatic advance_cycle();
    sb_entry_t  exp_e;
    logic       exc;
    logic       exp_valid;
    logic       exp_trap;
    logic [2:0] exp_intr;
    be_t        rmask;
    be_t        wmask;
    exc       = commit_valid_i && ex_valid_i && !commit_drop_i;
    exp_valid = (commit_ack_i && !ex_valid_i && !commit_drop_i) ||
                (exc && (ex_cause_i inside {32'd8, 32'd9, 32'd11}));
    exp_trap  = exc && !ex_cause_i[31];
    exp_intr  = sticky_intr;  // Code left by earlier commits
    exp_e     = model[commit_pointer_i];
    if (exc) begin
      sticky_intr = ex_cause_i[31] ? 3'd5 : 3'd3;
    end
    if (exp_valid) begin
      sticky_intr = 3'd0;
    end
    if (decoded_valid_i && decoded_ack_i && !flush_unissued_i) begin
      model[issue_pointer_i]           = '0;
      model[issue_pointer_i].insn      = held_insn;
      model[issue_pointer_i].rs1_rdata = rs1_rdata_i;
      model[issue_pointer_i].rs2_rdata = rs2_rdata_i;
    end
    rmask = (lsu_fu_i == FU_LOAD) ? lsu_be_i : '0;
    wmask = (lsu_fu_i == FU_STORE) ? lsu_be_i : '0;
    if (rmask != '0) begin
      model[lsu_id_i].lsu_addr  = lsu_vaddr_i;
      model[lsu_id_i].lsu_rmask = rmask;
    end else if (wmask != '0) begin
      model[lsu_id_i].lsu_addr  = lsu_vaddr_i;
      model[lsu_id_i].lsu_wmask = wmask;
      model[lsu_id_i].lsu_wdata = store_data_i;
    end
    if (issue_ack_i) begin
      held_valid = 1'b0;
    end
    if (!held_valid) begin
      held_valid = fetch_valid_i;
      held_insn  = fetch_compressed_i ? {16'h0000, fetch_insn_i[15:0]} : fetch_insn_i;
    end
    if (flush_i) begin
      held_valid = 1'b0;
    end
    @(negedge clk_i);
    compare_field("rvfi_valid_o", 32'(exp_valid), 32'(rvfi_valid_o));
    compare_field("rvfi_trap_o", 32'(exp_trap), 32'(rvfi_trap_o));
    compare_field("rvfi_intr_o", 32'(exp_intr), 32'(rvfi_intr_o));
    if (exp_valid) begin  // Commit-cycle payload inputs still held
      compare_field("rvfi_insn_o", exp_e.insn, rvfi_insn_o);
      compare_field("rvfi_rs1_rdata_o", exp_e.rs1_rdata, rvfi_rs1_rdata_o);
      compare_field("rvfi_rs2_rdata_o", exp_e.rs2_rdata, rvfi_rs2_rdata_o);
      compare_field("rvfi_mem_addr_o", exp_e.lsu_addr, rvfi_mem_addr_o);
      compare_field("rvfi_mem_rmask_o", 32'(exp_e.lsu_rmask), 32'(rvfi_mem_rmask_o));
      compare_field("rvfi_mem_wmask_o", 32'(exp_e.lsu_wmask), 32'(rvfi_mem_wmask_o));
      compare_field("rvfi_mem_wdata_o", exp_e.lsu_wdata, rvfi_mem_wdata_o);
      compare_field("rvfi_mem_rdata_o", result_i, rvfi_mem_rdata_o);
      compare_field("rvfi_rd_wdata_o", wdata_i, rvfi_rd_wdata_o);
      compare_field("rvfi_pc_rdata_o", pc_i, rvfi_pc_rdata_o);
      compare_field("rvfi_cause_o", ex_cause_i, rvfi_cause_o);
      compare_field("rvfi_mode_o", 32'(priv_lvl_i), 32'(rvfi_mode_o));
      compare_field("rvfi_rs1_addr_o", 32'(rs1_addr_i), 32'(rvfi_rs1_addr_o));
      compare_field("rvfi_rs2_addr_o", 32'(rs2_addr_i), 32'(rvfi_rs2_addr_o));
      compare_field("rvfi_rd_addr_o", 32'(rd_addr_i), 32'(rvfi_rd_addr_o));
    end
    clear_strobes();
  endtask

  initial begin
    rng_state        = 32'h5f762994;
    rst_ni           = 1'b0;
    fetch_insn_i     = '0;
    issue_pointer_i  = '0;
    rs1_rdata_i      = '0;
    rs2_rdata_i      = '0;
    lsu_be_i         = '0;
    lsu_vaddr_i      = '0;
    lsu_id_i         = '0;
    store_data_i     = '0;
    commit_pointer_i = '0;
    ex_cause_i       = '0;
    priv_lvl_i       = '0;
    rs1_addr_i       = '0;
    rs2_addr_i       = '0;
    rd_addr_i        = '0;
    wdata_i          = '0;
    result_i         = '0;
    pc_i             = '0;
    clear_strobes();
    foreach (model[i]) model[i] = '0;
    held_valid  = 1'b0;
    held_insn   = '0;
    sticky_intr = 3'd0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (3) advance_cycle();  // Quiet after reset

    // Every entry once, cycling load, store, other and no annotation
    for (int k = 0; k < SB_ENTRIES; k++) begin
      fetch_word(k[0]);
      advance_cycle();
      issue_entry(trans_id_t'(k));
      advance_cycle();
      annotate_entry(trans_id_t'(k), lsu_fu_e'(2'(k + 1)));
      advance_cycle();
      commit_entry(trans_id_t'(k), 1'b0, 32'd0, 1'b0);
      advance_cycle();
    end

    // Issue and store annotation on one entry in the same cycle
    fetch_word(1'b0);
    advance_cycle();
    issue_entry(3'd4);
    annotate_entry(3'd4, FU_STORE);
    advance_cycle();

    // ----------------------------------------
    // Classification and sticky intr code
    // ----------------------------------------
    commit_entry(3'd4, 1'b1, 32'd2, 1'b0);  // Illegal instruction
    advance_cycle();
    advance_cycle();
    commit_entry(3'd4, 1'b0, 32'd0, 1'b0);  // Reports 3
    advance_cycle();
    commit_entry(3'd4, 1'b0, 32'd0, 1'b0);  // Back to 0
    advance_cycle();
    commit_entry(3'd4, 1'b1, 32'h8000_0007, 1'b0);  // Timer interrupt
    advance_cycle();
    commit_entry(3'd4, 1'b0, 32'd0, 1'b0);  // Reports 5
    advance_cycle();
    commit_entry(3'd4, 1'b1, 32'd11, 1'b0);
    advance_cycle();
    commit_entry(3'd4, 1'b1, 32'd8, 1'b0);
    advance_cycle();
    commit_entry(3'd4, 1'b1, 32'd9, 1'b0);
    advance_cycle();
    commit_entry(3'd4, 1'b0, 32'd0, 1'b1);  // Dropped
    advance_cycle();

    // Held word survives a second fetch until acknowledged
    fetch_word(1'b0);
    advance_cycle();
    fetch_word(1'b1);
    advance_cycle();
    issue_entry(3'd5);
    advance_cycle();
    fetch_word(1'b1);
    advance_cycle();
    issue_entry(3'd6);
    advance_cycle();
    // Flush empties the buffer for the next fetch
    fetch_word(1'b0);
    advance_cycle();
    flush_i = 1'b1;
    advance_cycle();
    fetch_word(1'b0);
    advance_cycle();
    issue_entry(3'd7);
    advance_cycle();
    for (int k = 5; k < SB_ENTRIES; k++) begin
      commit_entry(trans_id_t'(k), 1'b0, 32'd0, 1'b0);
      advance_cycle();
    end
    repeat (2) advance_cycle();

    if (i_dut.i_assert.any_failed) begin
      abort_run("A bound assertion on the trace outputs failed");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

/* rvfi_tracer.f */
hw/rvfi_cfg_pkg.sv
hw/rvfi_trace_pkg.sv
hw/rvfi_issue_wr_if.sv
hw/rvfi_issue_capture.sv
hw/rvfi_side_table.sv
hw/rvfi_commit_pack.sv
hw/rvfi_tracer.sv
testbench/rvfi_tracer_assert.sv
testbench/tb_rvfi_tracer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the trace monitor testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_rvfi_tracer
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f rvfi_tracer.f -o "sim_$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past a bound assertion so the testbench can report it
./obj_dir/"sim_$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
